//--- hw/lsab_pkg.sv
`default_nettype none

package lsab_pkg;

  // lane layout of the shared memory
  localparam int LANES      = 4;
  localparam int LANE_W     = 2;
  localparam int DATA_W     = 32;
  localparam int PTR_W      = 6;
  localparam int RAM_ADDR_W = 8;   // {lane, ptr}

  typedef logic [LANE_W-1:0]     lane_t;
  typedef logic [PTR_W-1:0]      ptr_t;
  typedef logic [DATA_W-1:0]     word_t;
  typedef logic [RAM_ADDR_W-1:0] ram_addr_t;
  typedef logic [LANES-1:0]      lane_mask_t;

  // occupancy thresholds
  localparam ptr_t LANE_CAP        = ptr_t'(63);
  localparam ptr_t NEAR_FULL_LEVEL = ptr_t'(55);

endpackage

`default_nettype wire

//--- hw/lane_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lane_ctrl (
  input  logic           CLK,
  input  logic           RST,
  input  logic           push_req,
  input  logic           pop_req,
  output logic           push_go,
  output logic           pop_go,
  output lsab_pkg::ptr_t wr_ptr,
  output lsab_pkg::ptr_t rd_ptr,
  output logic           empty,
  output logic           full,
  output logic           near_full
);
  import lsab_pkg::*;

  ptr_t count;
  ptr_t count_nxt;
  logic empty_nxt;
  logic full_nxt;
  logic near_full_nxt;

  // refuse on the lane's own flags
  assign push_go = push_req && !full;
  assign pop_go  = pop_req && !empty;

  always_comb begin
    case ({push_go, pop_go})
      2'b10:   count_nxt = count + ptr_t'(1);
      2'b01:   count_nxt = count - ptr_t'(1);
      default: count_nxt = count;   // idle or push and pop together
    endcase
  end

  // flags follow the count they will hold after the edge
  always_comb begin
    empty_nxt     = (count_nxt == '0);
    full_nxt      = (count_nxt == LANE_CAP);
    near_full_nxt = (count_nxt >= NEAR_FULL_LEVEL);
  end

  always_ff @(posedge CLK) begin
    if (RST) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      empty     <= 1'b1;
      full      <= 1'b0;
      near_full <= 1'b0;
    end else begin
      if (push_go) begin
        wr_ptr <= wr_ptr + ptr_t'(1);   // wraps inside the lane quarter
      end
      if (pop_go) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      count     <= count_nxt;
      empty     <= empty_nxt;
      full      <= full_nxt;
      near_full <= near_full_nxt;
    end
  end

  // count may not run past the lane capacity and wrap
  a_count_cap: assert property (
    @(posedge CLK) disable iff (RST)
    (count == LANE_CAP) |=> (count >= LANE_CAP - ptr_t'(1))
  ) else $error("lane count %0d wrapped past capacity", count);

  // empty flag must agree with the lane pointers
  a_empty_match: assert property (
    @(posedge CLK) disable iff (RST)
    empty == (wr_ptr == rd_ptr)
  ) else $error("empty flag %0b with pointers %0d and %0d", empty, wr_ptr, rd_ptr);

endmodule

`default_nettype wire

//--- hw/lane_ram.sv
`timescale 1ns/1ps
`default_nettype none

module lane_ram (
  input  logic                CLK,
  input  logic                we,
  input  lsab_pkg::ram_addr_t waddr,
  input  lsab_pkg::word_t     wdata,
  input  logic                re,
  input  lsab_pkg::ram_addr_t raddr,
  output lsab_pkg::word_t     rdata
);
  import lsab_pkg::*;

  // one quarter per lane
  word_t mem [0:(1 << RAM_ADDR_W) - 1];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // rdata holds until the next read
  always_ff @(posedge CLK) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

  // lane pointers keep reader and writer apart while the lane holds data
  a_no_collide: assert property (
    @(posedge CLK)
    !(we && re && (waddr == raddr))
  ) else $error("read and write on the same word %0h", waddr);

endmodule

`default_nettype wire

//--- hw/lsab_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsab_top (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 wr_en,
  input  lsab_pkg::lane_t      wr_lane,
  input  lsab_pkg::word_t      wr_data,
  input  logic                 rd_en,
  input  lsab_pkg::lane_t      rd_lane,
  output lsab_pkg::word_t      rd_data,
  output logic                 rd_valid,
  output lsab_pkg::lane_mask_t empty,
  output lsab_pkg::lane_mask_t full,
  output lsab_pkg::lane_mask_t near_full
);
  import lsab_pkg::*;

  lane_mask_t push_req;
  lane_mask_t pop_req;
  lane_mask_t push_go;
  lane_mask_t pop_go;
  ptr_t       wr_ptr [LANES];
  ptr_t       rd_ptr [LANES];

  logic       ram_we;
  ram_addr_t  ram_waddr;
  logic       ram_re;
  ram_addr_t  ram_raddr;
  word_t      ram_rdata;

  logic       rd_pend;   // memory read in flight

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    // at most one lane asks per side
    assign push_req[i] = wr_en && (wr_lane == lane_t'(i));
    assign pop_req[i]  = rd_en && (rd_lane == lane_t'(i));

    lane_ctrl u_lane (
      .CLK       (CLK),
      .RST       (RST),
      .push_req  (push_req[i]),
      .pop_req   (pop_req[i]),
      .push_go   (push_go[i]),
      .pop_go    (pop_go[i]),
      .wr_ptr    (wr_ptr[i]),
      .rd_ptr    (rd_ptr[i]),
      .empty     (empty[i]),
      .full      (full[i]),
      .near_full (near_full[i])
    );
  end

  // addressed lane drives the memory ports
  assign ram_we    = push_go[wr_lane];
  assign ram_waddr = {wr_lane, wr_ptr[wr_lane]};
  assign ram_re    = pop_go[rd_lane];
  assign ram_raddr = {rd_lane, rd_ptr[rd_lane]};

  lane_ram u_ram (
    .CLK   (CLK),
    .we    (ram_we),
    .waddr (ram_waddr),
    .wdata (wr_data),
    .re    (ram_re),
    .raddr (ram_raddr),
    .rdata (ram_rdata)
  );

  // memory register is stage 1 and the output register stage 2
  always_ff @(posedge CLK) begin
    if (RST) begin
      rd_pend  <= 1'b0;
      rd_valid <= 1'b0;
      rd_data  <= '0;
    end else begin
      rd_pend  <= ram_re;
      rd_valid <= rd_pend;
      if (rd_pend) begin
        rd_data <= ram_rdata;   // holds between reads
      end
    end
  end

  // every output word comes from a read accepted two cycles back
  a_rd_latency: assert property (
    @(posedge CLK) disable iff (RST)
    rd_valid |-> $past(rd_en && !empty[rd_lane], 2)
  ) else $error("rd_valid without an accepted read");

endmodule

`default_nettype wire

//--- bench/lsab_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsab_tb;
  import lsab_pkg::*;

  logic       CLK;
  logic       RST;
  logic       wr_en;
  lane_t      wr_lane;
  word_t      wr_data;
  logic       rd_en;
  lane_t      rd_lane;
  word_t      rd_data;
  logic       rd_valid;
  lane_mask_t empty;
  lane_mask_t full;
  lane_mask_t near_full;

  integer      seed = 32'hbeef_9e62;
  int          error_cnt = 0;
  int          check_cnt = 0;
  int unsigned cycle_cnt = 0;

  word_t       model_q [LANES][$];   // reference contents per lane
  word_t       exp_q [$];            // words owed on rd_data
  int unsigned due_q [$];            // cycle each word is owed

  lsab_top dut0 (
    .CLK       (CLK),
    .RST       (RST),
    .wr_en     (wr_en),
    .wr_lane   (wr_lane),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_lane   (rd_lane),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .empty     (empty),
    .full      (full),
    .near_full (near_full)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic word_t next_word();
    return word_t'($random(seed));
  endfunction

  function automatic lane_t rand_lane();
    return lane_t'($random(seed));
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic check_mask(input string name, input lane_mask_t got, input lane_mask_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      error_cnt++;
    end
  endtask

  // drives one cycle and updates the model from the previous state
  task automatic drive(input logic wr, input lane_t wl, input word_t wd,
                       input logic rd, input lane_t rl);
    int wsize;
    int rsize;
    @(posedge CLK);
    wr_en   <= wr;
    wr_lane <= wl;
    wr_data <= wd;
    rd_en   <= rd;
    rd_lane <= rl;
    wsize = model_q[wl].size();
    rsize = model_q[rl].size();
    if (rd && rsize > 0) begin
      exp_q.push_back(model_q[rl].pop_front());
      due_q.push_back(cycle_cnt + 3);   // drive edge plus two
    end
    if (wr && wsize < int'(LANE_CAP)) begin
      model_q[wl].push_back(wd);
    end
  endtask

  task automatic idle();
    drive(1'b0, '0, '0, 1'b0, '0);
  endtask

  task automatic write_word(input lane_t lane, input word_t data);
    drive(1'b1, lane, data, 1'b0, '0);
  endtask

  task automatic read_word(input lane_t lane);
    drive(1'b0, '0, '0, 1'b1, lane);
  endtask

  task automatic check_flags();
    lane_mask_t exp_empty;
    lane_mask_t exp_full;
    lane_mask_t exp_near;
    @(negedge CLK);
    for (int l = 0; l < LANES; l++) begin
      exp_empty[l] = (model_q[l].size() == 0);
      exp_full[l]  = (model_q[l].size() == int'(LANE_CAP));
      exp_near[l]  = (model_q[l].size() >= int'(NEAR_FULL_LEVEL));
    end
    check_mask("empty", empty, exp_empty);
    check_mask("full", full, exp_full);
    check_mask("near_full", near_full, exp_near);
  endtask

  task automatic settle();
    idle();   // accept edge of the last transfer
    check_flags();
  endtask

  task automatic wait_reads();
    int waited;
    waited = 0;
    idle();
    while (exp_q.size() > 0 && waited < 8) begin
      @(negedge CLK);
      waited++;
    end
    if (exp_q.size() > 0) begin
      $display("timed out waiting for rd_valid, %0d reads outstanding", exp_q.size());
      error_cnt++;
      exp_q.delete();
      due_q.delete();
    end
  endtask

  task automatic drain_lane(input lane_t lane);
    while (model_q[lane].size() > 0) begin
      read_word(lane);
    end
    wait_reads();
    check_flags();
  endtask

  // read results are matched here as they come out
  always @(negedge CLK) begin
    if (!RST) begin
      if (rd_valid) begin
        if (exp_q.size() == 0) begin
          $display("rd_valid high with no read outstanding");
          error_cnt++;
        end else begin
          if (cycle_cnt != due_q[0]) begin
            $display("rd_valid at cycle %0d but expected at cycle %0d", cycle_cnt, due_q[0]);
            error_cnt++;
          end
          check_word("rd_data", rd_data, exp_q.pop_front());
          due_q.delete(0);
        end
      end else if (due_q.size() > 0 && cycle_cnt > due_q[0]) begin
        $display("rd_valid missing at cycle %0d", due_q[0]);
        error_cnt++;
        exp_q.delete(0);
        due_q.delete(0);
      end
    end
  end

  task automatic test_reset();
    @(negedge CLK);
    check_mask("empty", empty, 4'b1111);
    check_mask("full", full, 4'b0000);
    check_mask("near_full", near_full, 4'b0000);
    check_word("rd_data", rd_data, '0);
    if (rd_valid !== 1'b0) begin
      $display("rd_valid is not low after reset");
      error_cnt++;
    end
  endtask

  task automatic test_single_lane_order();
    for (int i = 0; i < 8; i++) begin
      write_word(lane_t'(2), next_word());
    end
    settle();
    drain_lane(lane_t'(2));   // back-to-back reads
  endtask

  task automatic test_lane_isolation();
    for (int step = 0; step < 40; step++) begin
      drive(1'b1, rand_lane(), next_word(), (step % 3) != 0, rand_lane());
      settle();
    end
    wait_reads();
    for (int l = 0; l < LANES; l++) begin
      drain_lane(lane_t'(l));
    end
  endtask

  task automatic test_full_refusal();
    for (int i = 0; i < int'(LANE_CAP); i++) begin
      write_word(lane_t'(1), next_word());
    end
    settle();
    check_mask("full", full, 4'b0010);
    write_word(lane_t'(1), next_word());   // lane is full so this one is refused
    settle();
    check_mask("full", full, 4'b0010);
    drain_lane(lane_t'(1));
    check_mask("empty", empty, 4'b1111);
  endtask

  task automatic test_near_full();
    for (int n = 1; n <= int'(NEAR_FULL_LEVEL); n++) begin
      write_word(lane_t'(0), next_word());
      settle();
      if (n == int'(NEAR_FULL_LEVEL) - 1) begin
        check_mask("near_full", near_full, 4'b0000);
      end else if (n == int'(NEAR_FULL_LEVEL)) begin
        check_mask("near_full", near_full, 4'b0001);
      end
    end
    read_word(lane_t'(0));
    wait_reads();
    check_flags();
    check_mask("near_full", near_full, 4'b0000);   // back to 54
    drain_lane(lane_t'(0));
  endtask

  task automatic test_refused_and_simultaneous();
    logic seen;
    seen = 1'b0;
    read_word(lane_t'(3));   // lane 3 is empty
    idle();
    for (int n = 0; n < 10 && !seen; n++) begin
      @(negedge CLK);
      if (rd_valid) begin
        seen = 1'b1;
      end
    end
    if (seen) begin
      $display("rd_valid seen after a read of empty lane 3");
      error_cnt++;
    end
    for (int i = 0; i < 3; i++) begin
      write_word(lane_t'(3), next_word());
    end
    settle();
    check_mask("empty", empty, 4'b0111);   // lane 3 holds three words
    check_mask("full", full, 4'b0000);
    check_mask("near_full", near_full, 4'b0000);
    drive(1'b1, lane_t'(3), next_word(), 1'b1, lane_t'(3));
    settle();
    check_mask("empty", empty, 4'b0111);
    check_mask("full", full, 4'b0000);
    check_mask("near_full", near_full, 4'b0000);
    wait_reads();
    drain_lane(lane_t'(3));
  endtask

  initial begin
    RST     = 1'b1;
    wr_en   = 1'b0;
    wr_lane = '0;
    wr_data = '0;
    rd_en   = 1'b0;
    rd_lane = '0;
    repeat (10) @(posedge CLK);
    RST <= 1'b0;
    test_reset();
    test_single_lane_order();
    test_lane_isolation();
    test_full_refusal();
    test_near_full();
    test_refused_and_simultaneous();
    $display("checks %0d, errors %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/lsab_pkg.sv
hw/lane_ctrl.sv
hw/lane_ram.sv
hw/lsab_top.sv
bench/lsab_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= lsab_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
